/* tests/z80fi_stim.txt */
# name insn len regs_in regs_out known mask, all columns but the name in hex
# regs run A F B C D E H L IP from the top; mask bits run A F B C D E H L IP from bit 8
rlc_b 000000CB 2 12008556789ABCDE0100 12010B56789ABCDE0102 1 000
rrc_a 00000FCB 2 01293456789ABCDE0200 80A93456789ABCDE0202 1 000
rl_c 000011CB 2 12013480789ABCDE0300 12013401789ABCDE0302 1 000
rl_d 000012CB 2 12003456809ABCDE0400 12453456009ABCDE0402 1 000
rr_e 00001BCB 2 120134567802BCDE0500 128434567881BCDE0502 1 000
rr_l 00001DCB 2 12003456789ABCFF0600 12013456789ABC7F0602 1 000
rlc_h 000004CB 2 12FF3456789A3CDE0700 122C3456789A78DE0702 1 000
sla_a 000027CB 2 C3003456789ABCDE0800 86813456789ABCDE0802 1 000
sra_b 000028CB 2 12288156789ABCDE0900 12ADC056789ABCDE0902 1 000
sll_c 000031CB 2 12003400789ABCDE0A00 12003401789ABCDE0A02 1 000
srl_d 00003ACB 2 12003456019ABCDE0B00 12453456009ABCDE0B02 1 000
sla_e_bad_c 000023CB 2 120034567840BCDE0C00 128134567880BCDE0C02 1 080
srl_h_bad_h 00003CCB 2 12003456789AF0DE0D00 12043456789A79DE0D02 1 004
ld_a_b 00000078 1 12003456789ABCDE0E00 34003456789ABCDE0E01 1 000
ld_l_h 0000006C 1 12553456789ABCDE0F00 12553456789ABCBC0F01 1 000
ld_d_e_bad_ip 00000053 1 12003456789ABCDE1000 120034569A9ABCDE1002 1 001
ld_c_c 00000049 1 12003456789ABCDE1100 12003456789ABCDE1101 1 000
rlc_mem_hl 000006CB 2 12003456789ABCDE1200 FFFFFFFFFFFFFFFFFFFF 0 000
nop 00000000 1 12003456789ABCDE1300 12003456789ABCDE1301 0 000
halt 00000076 1 12003456789ABCDE1400 FFFFFFFFFFFFFFFFFFFF 0 000
ld_a_mem_hl 0000007E 1 12003456789ABCDE1500 AA003456789ABCDE1501 0 000
rlc_a_bad_af 000007CB 2 80003456789ABCDE1600 00453456789ABCDE1602 1 180

/* list.f */
hdl/z80fi_pkg.sv
hdl/z80fi_insn_spec_rr_rlc_reg.sv
hdl/z80fi_insn_spec_shift_reg.sv
hdl/z80fi_insn_spec_ld_reg_reg.sv
hdl/z80fi_spec_select.sv
hdl/z80fi_retire_checker.sv
hdl/z80fi_checker_top.sv
tests/z80fi_checker_chk.sv
tests/z80fi_checker_tb.sv

/* tests/z80fi_checker_tb.sv */
// Testbench for the Z80 retirement checker.
// Reads retired-instruction records from the stim file, drives them with
// occasional idle gaps and checks every result strobe in order.

`timescale 1ns/100ps
`default_nettype none

module z80fi_checker_tb
    import z80fi_pkg::*;
();

    localparam int ERR_COUNT_W = 16;
    localparam int MAX_RECORDS = 64;

    logic                   clk;
    logic                   rst;
    logic                   retire_valid;
    insn_t                  retire_insn;
    insn_len_t              retire_len;
    regset_t                retire_regs_in;
    regset_t                retire_regs_out;
    logic                   check_valid;
    logic                   check_known;
    logic                   check_pass;
    regmask_t               check_mask;
    logic [ERR_COUNT_W-1:0] error_count;

    string     rec_name  [MAX_RECORDS];
    insn_t     rec_insn  [MAX_RECORDS];
    insn_len_t rec_len   [MAX_RECORDS];
    regset_t   rec_in    [MAX_RECORDS];
    regset_t   rec_out   [MAX_RECORDS];
    logic      rec_known [MAX_RECORDS];
    regmask_t  rec_mask  [MAX_RECORDS];

    int     num_records;
    int     expected_failures;
    int     exp_count;
    int     results_seen;
    int     errors;
    bit     load_done;
    integer seed;
    int     pending[$];

    z80fi_checker_top #(
        .ERR_COUNT_W (ERR_COUNT_W)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .retire_valid    (retire_valid),
        .retire_insn     (retire_insn),
        .retire_len      (retire_len),
        .retire_regs_in  (retire_regs_in),
        .retire_regs_out (retire_regs_out),
        .check_valid     (check_valid),
        .check_known     (check_known),
        .check_pass      (check_pass),
        .check_mask      (check_mask),
        .error_count     (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input string field,
                             input logic [79:0] expected, input logic [79:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s %s: expected %0h, actual %0h", name, field, expected, actual);
        end
    endtask

    task automatic load_records();
        int        fd;
        int        n;
        string     line;
        string     name;
        insn_t     insn;
        insn_len_t len;
        regset_t   rin;
        regset_t   rout;
        logic      known;
        regmask_t  mask;
        fd = $fopen("tests/z80fi_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file tests/z80fi_stim.txt.");
        end else begin
            while (!$feof(fd) && num_records < MAX_RECORDS) begin
                n = $fgets(line, fd);
                // Lines starting with a hash are column notes.
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h",
                                name, insn, len, rin, rout, known, mask);
                    if (n == 7) begin
                        rec_name[num_records]  = name;
                        rec_insn[num_records]  = insn;
                        rec_len[num_records]   = len;
                        rec_in[num_records]    = rin;
                        rec_out[num_records]   = rout;
                        rec_known[num_records] = known;
                        rec_mask[num_records]  = mask;
                        if (known && mask != '0) begin
                            expected_failures++;
                        end
                        num_records++;
                    end else if (n > 0) begin
                        errors++;
                        $display("Malformed stimulus line was skipped: %s", line);
                    end
                end
            end
            $fclose(fd);
            if (num_records == 0) begin
                errors++;
                $display("The stimulus file holds no records.");
            end
        end
    endtask

    task automatic drive_record(input int idx);
        retire_valid    = 1'b1;
        retire_insn     = rec_insn[idx];
        retire_len      = rec_len[idx];
        retire_regs_in  = rec_in[idx];
        retire_regs_out = rec_out[idx];
        pending.push_back(idx);
    endtask

    // Results are registered, so they are stable at the falling edge.
    always @(negedge clk) begin : monitor
        int idx;
        if (check_valid === 1'b1) begin
            if (pending.size() == 0) begin
                errors++;
                $display("A result strobe arrived at %0t with no record outstanding.", $time);
            end else begin
                idx = pending.pop_front();
                check_val(rec_name[idx], "known", rec_known[idx], check_known);
                check_val(rec_name[idx], "mask", rec_mask[idx], check_mask);
                check_val(rec_name[idx], "pass", rec_mask[idx] == '0, check_pass);
                if (rec_known[idx] && rec_mask[idx] != '0 &&
                    exp_count < (2 ** ERR_COUNT_W) - 1) begin
                    exp_count++;
                end
                check_val(rec_name[idx], "error_count", exp_count, error_count);
                results_seen++;
            end
        end
    end

    initial begin : stimulus
        integer draw;
        rst             = 1'b1;
        retire_valid    = 1'b0;
        retire_insn     = '0;
        retire_len      = '0;
        retire_regs_in  = '0;
        retire_regs_out = '0;
        seed            = 51823;
        load_records();
        load_done = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < num_records; i++) begin
            draw = $random(seed);
            if (draw[1:0] == 2'b00) begin
                retire_valid = 1'b0;
                repeat (1 + draw[2]) @(negedge clk);
            end
            drive_record(i);
            @(negedge clk);
        end
        retire_valid = 1'b0;
        wait (results_seen == num_records);
        repeat (2) @(negedge clk);
        check_val("final", "error_count", expected_failures, error_count);
        errors += DUT.u_checker.u_chk.assert_failures;
        $display("Done: %0d records, %0d results, error_count %0d, %0d testbench errors",
                 num_records, results_seen, error_count, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        wait (load_done);
        repeat (num_records * 20 + 100) @(posedge clk);
        $display("Timeout: the records did not all produce results within %0d cycles.",
                 num_records * 20 + 100);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/z80fi_checker_chk.sv */
// Assertion checks for the retirement checker.
// Covers the one-cycle result strobe, the pass flag and mask against the
// record's own comparison, and the error counter, which may only grow
// outside reset.

`timescale 1ns/100ps
`default_nettype none

module z80fi_checker_chk
    import z80fi_pkg::*;
#(
    parameter int ERR_COUNT_W = 16
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   retire_valid,
    input regset_t                retire_regs_out,
    input regset_t                sel_regs,
    input logic                   sel_known,
    input logic                   check_valid,
    input logic                   check_pass,
    input regmask_t               check_mask,
    input logic [ERR_COUNT_W-1:0] error_count
);

    int assert_failures = 0;

    // Every record taken gives a result strobe in the next cycle, and only then.
    assert property (@(posedge clk) disable iff (rst) retire_valid |=> check_valid)
        else begin
            assert_failures++;
            $error("check_valid missing one cycle after retire_valid");
        end

    assert property (@(posedge clk) disable iff (rst) !retire_valid |=> !check_valid)
        else begin
            assert_failures++;
            $error("check_valid high without a record in the previous cycle");
        end

    // A record that matches its specification as a whole, or that no block
    // claims, reads as a pass with a clean mask in the next cycle.
    assert property (@(posedge clk) disable iff (rst)
                     retire_valid |=>
                     ((check_pass && check_mask == '0) ==
                      $past(!sel_known || retire_regs_out == sel_regs)))
        else begin
            assert_failures++;
            $error("check_pass or check_mask disagrees with the record's comparison");
        end

    assert property (@(posedge clk) disable iff (rst)
                     !$past(rst) |-> (error_count >= $past(error_count)))
        else begin
            assert_failures++;
            $error("error_count decreased outside reset");
        end

endmodule

bind z80fi_retire_checker z80fi_checker_chk #(
    .ERR_COUNT_W (ERR_COUNT_W)
) u_chk (
    .clk             (clk),
    .rst             (rst),
    .retire_valid    (retire_valid),
    .retire_regs_out (retire_regs_out),
    .sel_regs        (sel_regs),
    .sel_known       (sel_known),
    .check_valid     (check_valid),
    .check_pass      (check_pass),
    .check_mask      (check_mask),
    .error_count     (error_count)
);

`default_nettype wire

/* hdl/z80fi_checker_top.sv */
// Z80 retirement checker top level.
// Feeds each retired-instruction record to the three specification
// blocks, selects the claiming result and checks it against the core.

`timescale 1ns/100ps
`default_nettype none

module z80fi_checker_top
    import z80fi_pkg::*;
#(
    parameter int ERR_COUNT_W = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   retire_valid,
    input  insn_t                  retire_insn,
    input  insn_len_t              retire_len,
    input  regset_t                retire_regs_in,
    input  regset_t                retire_regs_out,
    output logic                   check_valid,
    output logic                   check_known,
    output logic                   check_pass,
    output regmask_t               check_mask,
    output logic [ERR_COUNT_W-1:0] error_count
);

    logic    rot_valid;
    logic    shift_valid;
    logic    ld_valid;
    regset_t rot_regs;
    regset_t shift_regs;
    regset_t ld_regs;
    regset_t sel_regs;
    logic    sel_known;

    z80fi_insn_spec_rr_rlc_reg u_spec_rot (
        .insn          (retire_insn),
        .len           (retire_len),
        .regs_in       (retire_regs_in),
        .spec_valid    (rot_valid),
        .spec_regs_out (rot_regs)
    );

    z80fi_insn_spec_shift_reg u_spec_shift (
        .insn          (retire_insn),
        .len           (retire_len),
        .regs_in       (retire_regs_in),
        .spec_valid    (shift_valid),
        .spec_regs_out (shift_regs)
    );

    z80fi_insn_spec_ld_reg_reg u_spec_ld (
        .insn          (retire_insn),
        .len           (retire_len),
        .regs_in       (retire_regs_in),
        .spec_valid    (ld_valid),
        .spec_regs_out (ld_regs)
    );

    z80fi_spec_select u_select (
        .rot_valid   (rot_valid),
        .shift_valid (shift_valid),
        .ld_valid    (ld_valid),
        .rot_regs    (rot_regs),
        .shift_regs  (shift_regs),
        .ld_regs     (ld_regs),
        .sel_regs    (sel_regs),
        .sel_known   (sel_known)
    );

    z80fi_retire_checker #(
        .ERR_COUNT_W (ERR_COUNT_W)
    ) u_checker (
        .clk             (clk),
        .rst             (rst),
        .retire_valid    (retire_valid),
        .retire_regs_out (retire_regs_out),
        .sel_regs        (sel_regs),
        .sel_known       (sel_known),
        .check_valid     (check_valid),
        .check_known     (check_known),
        .check_pass      (check_pass),
        .check_mask      (check_mask),
        .error_count     (error_count)
    );

endmodule

`default_nettype wire

/* hdl/z80fi_retire_checker.sv */
// Retirement result checker.
// Compares the register set the core claims with the specified one, field
// by field, and presents the mismatch mask one cycle after the record.
// Also keeps a saturating count of failing known records.

`timescale 1ns/100ps
`default_nettype none

module z80fi_retire_checker
    import z80fi_pkg::*;
#(
    parameter int ERR_COUNT_W = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   retire_valid,
    input  regset_t                retire_regs_out,
    input  regset_t                sel_regs,
    input  logic                   sel_known,
    output logic                   check_valid,
    output logic                   check_known,
    output logic                   check_pass,
    output regmask_t               check_mask,
    output logic [ERR_COUNT_W-1:0] error_count
);

    localparam logic [ERR_COUNT_W-1:0] ERR_MAX = '1;

    regmask_t diff;
    regmask_t next_mask;
    logic     record_fail;

    // Mask order is A, F, B, C, D, E, H, L, IP from bit 8 down to bit 0.
    assign diff = {
        retire_regs_out[REGSET_A_LSB +: 8]   != sel_regs[REGSET_A_LSB +: 8],
        retire_regs_out[REGSET_F_LSB +: 8]   != sel_regs[REGSET_F_LSB +: 8],
        retire_regs_out[REGSET_B_LSB +: 8]   != sel_regs[REGSET_B_LSB +: 8],
        retire_regs_out[REGSET_C_LSB +: 8]   != sel_regs[REGSET_C_LSB +: 8],
        retire_regs_out[REGSET_D_LSB +: 8]   != sel_regs[REGSET_D_LSB +: 8],
        retire_regs_out[REGSET_E_LSB +: 8]   != sel_regs[REGSET_E_LSB +: 8],
        retire_regs_out[REGSET_H_LSB +: 8]   != sel_regs[REGSET_H_LSB +: 8],
        retire_regs_out[REGSET_L_LSB +: 8]   != sel_regs[REGSET_L_LSB +: 8],
        retire_regs_out[REGSET_IP_LSB +: 16] != sel_regs[REGSET_IP_LSB +: 16]
    };

    // An unclaimed opcode has no specified result, so its mask reads clean.
    assign next_mask   = sel_known ? diff : '0;
    assign record_fail = retire_valid && sel_known && (diff != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            check_valid <= 1'b0;
            check_known <= 1'b0;
        end else begin
            check_valid <= retire_valid;
            check_known <= retire_valid && sel_known;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_valid) begin
            check_mask <= next_mask;
        end
    end

    assign check_pass = (check_mask == '0);

    // The count is updated at the same edge as the result, so it already
    // includes the record shown on check_mask. It sticks at its maximum.
    always_ff @(posedge clk) begin
        if (rst) begin
            error_count <= '0;
        end else if (record_fail && (error_count != ERR_MAX)) begin
            error_count <= error_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/z80fi_spec_select.sv */
// Specification selector.
// Passes on the register set of whichever block claims the instruction
// and reports whether any block claimed it at all.

`timescale 1ns/100ps
`default_nettype none

module z80fi_spec_select
    import z80fi_pkg::*;
(
    input  logic    rot_valid,
    input  logic    shift_valid,
    input  logic    ld_valid,
    input  regset_t rot_regs,
    input  regset_t shift_regs,
    input  regset_t ld_regs,
    output regset_t sel_regs,
    output logic    sel_known
);

    logic [2:0] claim;

    assign claim     = {rot_valid, shift_valid, ld_valid};
    assign sel_known = |claim;

    // The opcode groups are disjoint, so at most one claim bit is ever set.
    // With no claim the rotate output is passed on and the checker drops it.
    always_comb begin
        case (claim)
            3'b100:  sel_regs = rot_regs;
            3'b010:  sel_regs = shift_regs;
            3'b001:  sel_regs = ld_regs;
            default: sel_regs = rot_regs;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/z80fi_insn_spec_ld_reg_reg.sv */
// LD r,r' specification for the one-byte register-to-register load.
// Flags are untouched; only the destination register and IP change.

`timescale 1ns/100ps
`default_nettype none

module z80fi_insn_spec_ld_reg_reg
    import z80fi_pkg::*;
(
    input  insn_t     insn,
    input  insn_len_t len,
    input  regset_t   regs_in,
    output logic      spec_valid,
    output regset_t   spec_regs_out
);

    logic [2:0] dst;
    logic [2:0] src;
    reg8_t      rdata;

    assign dst = insn[5:3];
    assign src = insn[2:0];

    // Code 6 on either side is HALT or a memory form, neither of which is ours.
    assign spec_valid = (len == 3'd1) && (insn[7:6] == 2'b01) &&
                        (dst != 3'd6) && (src != 3'd6);

    always_comb begin
        case (src)
            REG_A:   rdata = regs_in[REGSET_A_LSB +: 8];
            REG_B:   rdata = regs_in[REGSET_B_LSB +: 8];
            REG_C:   rdata = regs_in[REGSET_C_LSB +: 8];
            REG_D:   rdata = regs_in[REGSET_D_LSB +: 8];
            REG_E:   rdata = regs_in[REGSET_E_LSB +: 8];
            REG_H:   rdata = regs_in[REGSET_H_LSB +: 8];
            REG_L:   rdata = regs_in[REGSET_L_LSB +: 8];
            default: rdata = '0;
        endcase
    end

    always_comb begin
        spec_regs_out = regs_in;
        case (dst)
            REG_A:   spec_regs_out[REGSET_A_LSB +: 8] = rdata;
            REG_B:   spec_regs_out[REGSET_B_LSB +: 8] = rdata;
            REG_C:   spec_regs_out[REGSET_C_LSB +: 8] = rdata;
            REG_D:   spec_regs_out[REGSET_D_LSB +: 8] = rdata;
            REG_E:   spec_regs_out[REGSET_E_LSB +: 8] = rdata;
            REG_H:   spec_regs_out[REGSET_H_LSB +: 8] = rdata;
            REG_L:   spec_regs_out[REGSET_L_LSB +: 8] = rdata;
            default: ;
        endcase
        spec_regs_out[REGSET_IP_LSB +: 16] =
            addr16_t'(regs_in[REGSET_IP_LSB +: 16] + addr16_t'(len));
    end

endmodule

`default_nettype wire

/* hdl/z80fi_insn_spec_shift_reg.sv */
// CB-prefixed shift specification: SLA, SRA, SLL and SRL on a register.
// Flags follow the same rule as the CB rotates.

`timescale 1ns/100ps
`default_nettype none

module z80fi_insn_spec_shift_reg
    import z80fi_pkg::*;
(
    input  insn_t     insn,
    input  insn_len_t len,
    input  regset_t   regs_in,
    output logic      spec_valid,
    output regset_t   spec_regs_out
);

    localparam logic [1:0] SH_SLA = 2'b00;
    localparam logic [1:0] SH_SRA = 2'b01;
    localparam logic [1:0] SH_SLL = 2'b10;
    localparam logic [1:0] SH_SRL = 2'b11;

    logic [1:0] op;
    logic [2:0] r;
    reg8_t      f_in;
    reg8_t      rdata;
    reg8_t      wdata;
    logic       carry;
    reg8_t      f_out;
    addr16_t    ip_out;

    assign op   = insn[12:11];
    assign r    = insn[10:8];
    assign f_in = regs_in[REGSET_F_LSB +: 8];

    assign spec_valid = (len == 3'd2) && (insn[7:0] == 8'hCB) &&
                        (insn[15:13] == 3'b001) && (r != 3'd6);

    always_comb begin
        case (r)
            REG_A:   rdata = regs_in[REGSET_A_LSB +: 8];
            REG_B:   rdata = regs_in[REGSET_B_LSB +: 8];
            REG_C:   rdata = regs_in[REGSET_C_LSB +: 8];
            REG_D:   rdata = regs_in[REGSET_D_LSB +: 8];
            REG_E:   rdata = regs_in[REGSET_E_LSB +: 8];
            REG_H:   rdata = regs_in[REGSET_H_LSB +: 8];
            REG_L:   rdata = regs_in[REGSET_L_LSB +: 8];
            default: rdata = '0;
        endcase
    end

    // Left shifts lose bit 7 into carry, right shifts lose bit 0.
    always_comb begin
        case (op)
            SH_SLA:  wdata = {rdata[6:0], 1'b0};
            SH_SRA:  wdata = {rdata[7], rdata[7:1]};
            SH_SLL:  wdata = {rdata[6:0], 1'b1};
            SH_SRL:  wdata = {1'b0, rdata[7:1]};
            default: wdata = rdata;
        endcase
        carry = op[0] ? rdata[0] : rdata[7];
    end

    assign ip_out = regs_in[REGSET_IP_LSB +: 16] + addr16_t'(len);

    always_comb begin
        f_out              = f_in;
        f_out[FLAG_S_NUM]  = wdata[7];
        f_out[FLAG_Z_NUM]  = (wdata == 8'h00);
        f_out[FLAG_H_NUM]  = 1'b0;
        f_out[FLAG_PV_NUM] = parity8(wdata);
        f_out[FLAG_N_NUM]  = 1'b0;
        f_out[FLAG_C_NUM]  = carry;
    end

    always_comb begin
        spec_regs_out = regs_in;
        case (r)
            REG_A:   spec_regs_out[REGSET_A_LSB +: 8] = wdata;
            REG_B:   spec_regs_out[REGSET_B_LSB +: 8] = wdata;
            REG_C:   spec_regs_out[REGSET_C_LSB +: 8] = wdata;
            REG_D:   spec_regs_out[REGSET_D_LSB +: 8] = wdata;
            REG_E:   spec_regs_out[REGSET_E_LSB +: 8] = wdata;
            REG_H:   spec_regs_out[REGSET_H_LSB +: 8] = wdata;
            REG_L:   spec_regs_out[REGSET_L_LSB +: 8] = wdata;
            default: ;
        endcase
        spec_regs_out[REGSET_F_LSB +: 8]   = f_out;
        spec_regs_out[REGSET_IP_LSB +: 16] = ip_out;
    end

endmodule

`default_nettype wire

/* hdl/z80fi_insn_spec_rr_rlc_reg.sv */
// CB-prefixed rotate specification: RLC, RRC, RL and RR on a register.
// Rotates without carry feed the leaving bit back in; RL and RR behave as
// nine-bit rotates through the carry flag.

`timescale 1ns/100ps
`default_nettype none

module z80fi_insn_spec_rr_rlc_reg
    import z80fi_pkg::*;
(
    input  insn_t     insn,
    input  insn_len_t len,
    input  regset_t   regs_in,
    output logic      spec_valid,
    output regset_t   spec_regs_out
);

    logic       through_c;
    logic       right;
    logic [2:0] r;
    reg8_t      f_in;
    reg8_t      rdata;
    logic       shove_bit;
    reg8_t      wdata;
    reg8_t      f_out;
    addr16_t    ip_out;

    // Second byte is 000 t d rrr, with t for through carry and d for right.
    assign through_c = insn[12];
    assign right     = insn[11];
    assign r         = insn[10:8];
    assign f_in      = regs_in[REGSET_F_LSB +: 8];

    assign spec_valid = (len == 3'd2) && (insn[7:0] == 8'hCB) &&
                        (insn[15:13] == 3'b000) && (r != 3'd6);

    always_comb begin
        case (r)
            REG_A:   rdata = regs_in[REGSET_A_LSB +: 8];
            REG_B:   rdata = regs_in[REGSET_B_LSB +: 8];
            REG_C:   rdata = regs_in[REGSET_C_LSB +: 8];
            REG_D:   rdata = regs_in[REGSET_D_LSB +: 8];
            REG_E:   rdata = regs_in[REGSET_E_LSB +: 8];
            REG_H:   rdata = regs_in[REGSET_H_LSB +: 8];
            REG_L:   rdata = regs_in[REGSET_L_LSB +: 8];
            default: rdata = '0;
        endcase
    end

    // The entering bit is the old carry for RL/RR, else the bit that leaves.
    assign shove_bit = through_c ? f_in[FLAG_C_NUM] : rdata[right ? 0 : 7];
    assign wdata     = right ? {shove_bit, rdata[7:1]} : {rdata[6:0], shove_bit};
    assign ip_out    = regs_in[REGSET_IP_LSB +: 16] + addr16_t'(len);

    always_comb begin
        f_out              = f_in;
        f_out[FLAG_S_NUM]  = wdata[7];
        f_out[FLAG_Z_NUM]  = (wdata == 8'h00);
        f_out[FLAG_H_NUM]  = 1'b0;
        f_out[FLAG_PV_NUM] = parity8(wdata);
        f_out[FLAG_N_NUM]  = 1'b0;
        f_out[FLAG_C_NUM]  = rdata[right ? 0 : 7];
    end

    always_comb begin
        spec_regs_out = regs_in;
        case (r)
            REG_A:   spec_regs_out[REGSET_A_LSB +: 8] = wdata;
            REG_B:   spec_regs_out[REGSET_B_LSB +: 8] = wdata;
            REG_C:   spec_regs_out[REGSET_C_LSB +: 8] = wdata;
            REG_D:   spec_regs_out[REGSET_D_LSB +: 8] = wdata;
            REG_E:   spec_regs_out[REGSET_E_LSB +: 8] = wdata;
            REG_H:   spec_regs_out[REGSET_H_LSB +: 8] = wdata;
            REG_L:   spec_regs_out[REGSET_L_LSB +: 8] = wdata;
            default: ;
        endcase
        spec_regs_out[REGSET_F_LSB +: 8]   = f_out;
        spec_regs_out[REGSET_IP_LSB +: 16] = ip_out;
    end

endmodule

`default_nettype wire

/* hdl/z80fi_pkg.sv */
// Z80 retirement checker shared definitions.
// Holds the register-set layout, instruction and mask types, the Z80
// register codes, the flag bit positions and the parity helper used by
// the CB-prefixed specification blocks.

`default_nettype none

package z80fi_pkg;

    typedef logic [7:0]  reg8_t;
    typedef logic [15:0] addr16_t;

    // Register set packed as A, F, B, C, D, E, H, L, IP from the top down.
    typedef logic [79:0] regset_t;

    // Up to four instruction bytes, first byte in bits 7:0.
    typedef logic [31:0] insn_t;
    typedef logic [2:0]  insn_len_t;

    // One mismatch bit per field, A in bit 8 down to IP in bit 0.
    typedef logic [8:0]  regmask_t;

    localparam int REGSET_A_LSB  = 72;
    localparam int REGSET_F_LSB  = 64;
    localparam int REGSET_B_LSB  = 56;
    localparam int REGSET_C_LSB  = 48;
    localparam int REGSET_D_LSB  = 40;
    localparam int REGSET_E_LSB  = 32;
    localparam int REGSET_H_LSB  = 24;
    localparam int REGSET_L_LSB  = 16;
    localparam int REGSET_IP_LSB = 0;

    // Three-bit register codes as they appear in the opcode.
    // Code 6 selects (HL) and is not a register.
    localparam logic [2:0] REG_B = 3'd0;
    localparam logic [2:0] REG_C = 3'd1;
    localparam logic [2:0] REG_D = 3'd2;
    localparam logic [2:0] REG_E = 3'd3;
    localparam logic [2:0] REG_H = 3'd4;
    localparam logic [2:0] REG_L = 3'd5;
    localparam logic [2:0] REG_A = 3'd7;

    localparam int FLAG_C_NUM  = 0;
    localparam int FLAG_N_NUM  = 1;
    localparam int FLAG_PV_NUM = 2;
    localparam int FLAG_3_NUM  = 3;
    localparam int FLAG_H_NUM  = 4;
    localparam int FLAG_5_NUM  = 5;
    localparam int FLAG_Z_NUM  = 6;
    localparam int FLAG_S_NUM  = 7;

    // Even parity as the Z80 P/V flag reports it, 1 for an even count of ones.
    function automatic logic parity8(input reg8_t value);
        return ~^value;
    endfunction

endpackage

`default_nettype wire
